//--- verilog/cim_cfg.svh
// Tile configuration macros that the package, the RTL modules and the testbench include
`ifndef CIM_CFG_SVH
`define CIM_CFG_SVH

// Datapath
`define CIM_WORD_W 16
`define CIM_NUM_CIMS 4
`define CIM_ID_W $clog2(`CIM_NUM_CIMS)

// Memory sizes
`define CIM_PARAM_DEPTH 64
`define CIM_INTRES_DEPTH 64
`define CIM_ADDR_W 6 // Covers both 64-word memories

// Sequence lengths
`define CIM_NUM_PATCHES 4

// Intermediate-result map
`define CIM_CLASS_TOKEN_MEM 0
`define CIM_PATCH_MEM 1 // Patches follow the class token

// Parameter map
`define CIM_CLASS_TOKEN_OFF 0
`define CIM_POS_EMB_OFF 8

`endif

//--- verilog/cim_pkg.sv
// Shared bus, memory-request and FSM types that the tile files reference by scoped name
`default_nettype none

`include "cim_cfg.svh"

package cim_pkg;

    typedef enum logic [2:0] {
        NOP                           = 3'd0,
        PATCH_LOAD_BROADCAST_START_OP = 3'd1,
        PATCH_LOAD_BROADCAST_OP       = 3'd2,
        PARAM_STREAM_START_OP         = 3'd3,
        PARAM_STREAM_OP               = 3'd4,
        DENSE_BROADCAST_START_OP      = 3'd5,
        DENSE_BROADCAST_DATA_OP       = 3'd6
    } bus_op_t;

    typedef enum logic [2:0] {
        CIM_IDLE,
        CIM_PATCH_LOAD,
        CIM_CLASS_TOKEN,
        CIM_POS_EMB,
        CIM_DONE
    } cim_state_t;

    typedef struct packed {
        bus_op_t                          op;
        logic [`CIM_ID_W-1:0]             target_or_sender;
        logic [2:0][`CIM_WORD_W-1:0]      data;
    } bus_word_t;

    // One port request into a memory
    typedef struct packed {
        logic                   rd;
        logic                   wr;
        logic [`CIM_ADDR_W-1:0] addr;
        logic [`CIM_WORD_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                   start; // One-cycle pulse
        logic [`CIM_ADDR_W-1:0] addr;
        logic [1:0]             len;   // 1 or 3 words
    } tx_cmd_t;

endpackage

`default_nettype wire

//--- verilog/cim_mem.sv
// Parameter and intermediate-result memories with fixed-priority request selection
`default_nettype none

`include "cim_cfg.svh"

module cim_mem (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cim_pkg::mem_req_t      rx_param_req,
    input  cim_pkg::mem_req_t      ctrl_param_req,
    input  cim_pkg::mem_req_t      rx_intres_req,
    input  cim_pkg::mem_req_t      ctrl_intres_req,
    input  cim_pkg::mem_req_t      tx_intres_req,
    output logic [`CIM_WORD_W-1:0] param_rdata,
    output logic [`CIM_WORD_W-1:0] intres_rdata
);

    localparam int W = `CIM_WORD_W;

    logic [W-1:0] param_mem  [`CIM_PARAM_DEPTH];
    logic [W-1:0] intres_mem [`CIM_INTRES_DEPTH];

    cim_pkg::mem_req_t param_sel;
    cim_pkg::mem_req_t intres_sel;

    // Higher source wins whenever it asks for anything
    function automatic cim_pkg::mem_req_t pick(input cim_pkg::mem_req_t hi,
                                               input cim_pkg::mem_req_t lo);
        return (hi.rd || hi.wr) ? hi : lo;
    endfunction

    assign param_sel  = pick(rx_param_req, ctrl_param_req);
    assign intres_sel = pick(rx_intres_req, pick(ctrl_intres_req, tx_intres_req));

    always_ff @(posedge clk) begin
        if (param_sel.wr) begin
            param_mem[param_sel.addr] <= param_sel.wdata;
        end
        if (intres_sel.wr) begin
            intres_mem[intres_sel.addr] <= intres_sel.wdata;
        end
    end

    // Read data lands one cycle after the request
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            param_rdata  <= '0;
            intres_rdata <= '0;
        end else begin
            if (param_sel.rd) begin
                param_rdata <= param_mem[param_sel.addr];
            end
            if (intres_sel.rd) begin
                intres_rdata <= intres_mem[intres_sel.addr];
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/cim_bus_rx.sv
// Bus receive FSM that decodes opcodes, stores parameters and patches, and launches transmits
`default_nettype none

`include "cim_cfg.svh"

module cim_bus_rx #(
    parameter int ID = 0
) (
    input  logic               clk,
    input  logic               rst_n,
    input  cim_pkg::bus_word_t bus_in,
    output cim_pkg::mem_req_t  param_req,
    output cim_pkg::mem_req_t  intres_req,
    output logic               patch_loaded,
    output cim_pkg::tx_cmd_t   tx_cmd
);

    localparam int W     = `CIM_WORD_W;
    localparam int AW    = `CIM_ADDR_W;
    localparam int IDW   = `CIM_ID_W;
    localparam int PCW   = $clog2(`CIM_NUM_PATCHES + 1);
    localparam int NPATCH = `CIM_NUM_PATCHES;

    logic [AW-1:0]  base_addr;
    logic [AW-1:0]  word_cnt;
    logic [1:0]     slot_idx;  // Data slot of the next streamed word
    logic [PCW-1:0] patch_cnt;
    logic           for_me;
    logic           patch_room;

    assign for_me     = (bus_in.target_or_sender == IDW'(ID));
    assign patch_room = (patch_cnt < PCW'(NPATCH));

    // Writes go straight from the bus so the word is stored at the sampling edge
    always_comb begin
        param_req  = '0;
        intres_req = '0;
        if (bus_in.op == cim_pkg::PARAM_STREAM_OP && for_me) begin
            param_req.wr    = 1'b1;
            param_req.addr  = base_addr + word_cnt;
            param_req.wdata = bus_in.data[slot_idx];
        end
        if (bus_in.op == cim_pkg::PATCH_LOAD_BROADCAST_OP && patch_room) begin
            intres_req.wr    = 1'b1;
            intres_req.addr  = AW'(`CIM_PATCH_MEM) + AW'(patch_cnt);
            intres_req.wdata = bus_in.data[0];
        end
    end

    always_ff @(posedge clk) begin
        if (bus_in.op == cim_pkg::PARAM_STREAM_START_OP) begin
            base_addr <= bus_in.data[0][AW-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            word_cnt     <= '0;
            slot_idx     <= '0;
            patch_cnt    <= '0;
            patch_loaded <= 1'b0;
            tx_cmd       <= '0;
        end else begin
            patch_loaded <= 1'b0;
            tx_cmd.start <= 1'b0;
            case (bus_in.op)
                cim_pkg::PARAM_STREAM_START_OP: begin
                    word_cnt <= '0;
                    slot_idx <= '0;
                end
                cim_pkg::PARAM_STREAM_OP: begin
                    if (for_me) begin
                        word_cnt <= word_cnt + AW'(1);
                        slot_idx <= (slot_idx == 2'd2) ? 2'd0 : slot_idx + 2'd1;
                    end
                end
                cim_pkg::PATCH_LOAD_BROADCAST_START_OP: begin
                    patch_cnt <= '0;
                end
                cim_pkg::PATCH_LOAD_BROADCAST_OP: begin
                    if (patch_room) begin
                        patch_cnt    <= patch_cnt + PCW'(1);
                        patch_loaded <= (patch_cnt == PCW'(NPATCH - 1)); // Last patch
                    end
                end
                cim_pkg::DENSE_BROADCAST_START_OP: begin
                    if (for_me) begin
                        tx_cmd.start <= 1'b1;
                        tx_cmd.addr  <= bus_in.data[0][AW-1:0];
                        tx_cmd.len   <= (bus_in.data[1] == W'(1)) ? 2'd1 : 2'd3;
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/cim_compute_ctrl.sv
// Inference control FSM running the class-token copy and positional-embedding add
`default_nettype none

`include "cim_cfg.svh"

module cim_compute_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   patch_loaded,
    input  logic [`CIM_WORD_W-1:0] param_rdata,
    input  logic [`CIM_WORD_W-1:0] intres_rdata,
    output cim_pkg::mem_req_t      param_req,
    output cim_pkg::mem_req_t      intres_req,
    output logic                   compute_busy
);

    localparam int W     = `CIM_WORD_W;
    localparam int AW    = `CIM_ADDR_W;
    localparam int IDX_W = $clog2(`CIM_NUM_PATCHES + 2);
    localparam int LAST  = `CIM_NUM_PATCHES; // Class token plus every patch

    cim_pkg::cim_state_t state;

    logic [1:0]       step;   // Read, combine, write
    logic [IDX_W-1:0] idx;
    logic [W-1:0]     hold_q;

    assign compute_busy = (state == cim_pkg::CIM_CLASS_TOKEN) ||
                          (state == cim_pkg::CIM_POS_EMB);

    always_comb begin
        param_req  = '0;
        intres_req = '0;
        case (state)
            cim_pkg::CIM_CLASS_TOKEN: begin
                if (step == 2'd0) begin
                    param_req.rd   = 1'b1;
                    param_req.addr = AW'(`CIM_CLASS_TOKEN_OFF);
                end
                if (step == 2'd2) begin
                    intres_req.wr    = 1'b1;
                    intres_req.addr  = AW'(`CIM_CLASS_TOKEN_MEM);
                    intres_req.wdata = hold_q;
                end
            end
            cim_pkg::CIM_POS_EMB: begin
                if (step == 2'd0) begin
                    param_req.rd    = 1'b1;
                    param_req.addr  = AW'(`CIM_POS_EMB_OFF) + AW'(idx);
                    intres_req.rd   = 1'b1;
                    intres_req.addr = AW'(`CIM_CLASS_TOKEN_MEM) + AW'(idx);
                end
                if (step == 2'd2) begin
                    intres_req.wr    = 1'b1;
                    intres_req.addr  = AW'(`CIM_CLASS_TOKEN_MEM) + AW'(idx);
                    intres_req.wdata = hold_q;
                end
            end
            default: begin
            end
        endcase
    end

    // Sum wraps to the word width
    always_ff @(posedge clk) begin
        if (step == 2'd1) begin
            hold_q <= (state == cim_pkg::CIM_POS_EMB) ? param_rdata + intres_rdata
                                                       : param_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= cim_pkg::CIM_IDLE;
            step  <= '0;
            idx   <= '0;
        end else begin
            case (state)
                cim_pkg::CIM_IDLE: begin
                    state <= cim_pkg::CIM_PATCH_LOAD;
                end
                cim_pkg::CIM_PATCH_LOAD,
                cim_pkg::CIM_DONE: begin
                    if (patch_loaded) begin // New image restarts the sequence
                        state <= cim_pkg::CIM_CLASS_TOKEN;
                        step  <= '0;
                    end
                end
                cim_pkg::CIM_CLASS_TOKEN: begin
                    step <= (step == 2'd2) ? 2'd0 : step + 2'd1;
                    if (step == 2'd2) begin
                        state <= cim_pkg::CIM_POS_EMB;
                        idx   <= '0;
                    end
                end
                cim_pkg::CIM_POS_EMB: begin
                    step <= (step == 2'd2) ? 2'd0 : step + 2'd1;
                    if (step == 2'd2) begin
                        idx <= idx + IDX_W'(1);
                        if (idx == IDX_W'(LAST)) begin
                            state <= cim_pkg::CIM_DONE;
                        end
                    end
                end
                default: begin
                    state <= cim_pkg::CIM_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/cim_bus_tx.sv
// Fill-and-send FSM that gathers result words and drives one dense broadcast beat
`default_nettype none

`include "cim_cfg.svh"

module cim_bus_tx #(
    parameter int ID = 0
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cim_pkg::tx_cmd_t       tx_cmd,
    input  logic [`CIM_WORD_W-1:0] intres_rdata,
    output cim_pkg::mem_req_t      intres_req,
    output cim_pkg::bus_word_t     bus_out,
    output logic                   bus_drive,
    output logic                   tx_busy
);

    localparam int W   = `CIM_WORD_W;
    localparam int AW  = `CIM_ADDR_W;
    localparam int IDW = `CIM_ID_W;

    typedef enum logic [1:0] {TX_IDLE, TX_READ, TX_FILL, TX_SEND} tx_state_t;

    tx_state_t         state;
    logic [AW-1:0]     addr_q;
    logic [1:0]        len_q;
    logic [1:0]        word_idx;
    logic [1:0]        slot;
    logic [2:0][W-1:0] data_q;
    logic              last_word;

    assign slot      = (len_q == 2'd1) ? 2'd2 : word_idx; // Single word rides in slot 2
    assign last_word = (word_idx == len_q - 2'd1);
    assign bus_drive = (state == TX_SEND);
    assign tx_busy   = (state != TX_IDLE);

    always_comb begin
        intres_req = '0;
        if (state == TX_READ) begin
            intres_req.rd   = 1'b1;
            intres_req.addr = addr_q + AW'(word_idx);
        end
    end

    always_comb begin
        bus_out.op               = bus_drive ? cim_pkg::DENSE_BROADCAST_DATA_OP : cim_pkg::NOP;
        bus_out.target_or_sender = IDW'(ID);
        bus_out.data             = data_q;
    end

    always_ff @(posedge clk) begin
        if (state == TX_IDLE && tx_cmd.start) begin
            addr_q <= tx_cmd.addr;
            len_q  <= tx_cmd.len;
            data_q <= '0; // Unused slots go out as zero
        end else if (state == TX_FILL) begin
            data_q[slot] <= intres_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= TX_IDLE;
            word_idx <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    word_idx <= '0;
                    if (tx_cmd.start) begin
                        state <= TX_READ;
                    end
                end
                TX_READ: state <= TX_FILL;
                TX_FILL: begin
                    if (last_word) begin
                        state <= TX_SEND;
                    end else begin
                        word_idx <= word_idx + 2'd1;
                        state    <= TX_READ;
                    end
                end
                default: state <= TX_IDLE; // Beat lasts one cycle
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/cim.sv
// Tile top level joining the bus FSMs, the compute FSM and the two memories
`default_nettype none

`include "cim_cfg.svh"

module cim #(
    parameter int ID = 0
) (
    input  logic               clk,
    input  logic               rst_n,
    input  cim_pkg::bus_word_t bus_in,
    output cim_pkg::bus_word_t bus_out,
    output logic               bus_drive,
    output logic               is_ready
);

    cim_pkg::mem_req_t rx_param_req;
    cim_pkg::mem_req_t rx_intres_req;
    cim_pkg::mem_req_t ctrl_param_req;
    cim_pkg::mem_req_t ctrl_intres_req;
    cim_pkg::mem_req_t tx_intres_req;
    cim_pkg::tx_cmd_t  tx_cmd;

    logic [`CIM_WORD_W-1:0] param_rdata;
    logic [`CIM_WORD_W-1:0] intres_rdata;
    logic                   patch_loaded;
    logic                   compute_busy;
    logic                   tx_busy;

    assign is_ready = !compute_busy && !tx_busy;

    cim_mem mem_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .rx_param_req    (rx_param_req),
        .ctrl_param_req  (ctrl_param_req),
        .rx_intres_req   (rx_intres_req),
        .ctrl_intres_req (ctrl_intres_req),
        .tx_intres_req   (tx_intres_req),
        .param_rdata     (param_rdata),
        .intres_rdata    (intres_rdata)
    );

    cim_bus_rx #(.ID(ID)) rx_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .bus_in       (bus_in),
        .param_req    (rx_param_req),
        .intres_req   (rx_intres_req),
        .patch_loaded (patch_loaded),
        .tx_cmd       (tx_cmd)
    );

    cim_compute_ctrl ctrl_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .patch_loaded (patch_loaded),
        .param_rdata  (param_rdata),
        .intres_rdata (intres_rdata),
        .param_req    (ctrl_param_req),
        .intres_req   (ctrl_intres_req),
        .compute_busy (compute_busy)
    );

    cim_bus_tx #(.ID(ID)) tx_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .tx_cmd       (tx_cmd),
        .intres_rdata (intres_rdata),
        .intres_req   (tx_intres_req),
        .bus_out      (bus_out),
        .bus_drive    (bus_drive),
        .tx_busy      (tx_busy)
    );

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
// Clock and reset source that the tile testbench top instantiates once
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD = 50; // 100 ns clock
    localparam int RST_CYCLES  = 2;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #5;
        rst_n = 1'b1; // Same skew as the bus inputs
    end

endmodule

`default_nettype wire

//--- sim/cim_tb.sv
// Testbench top that streams parameters, loads patches and checks the tile's broadcast results
`default_nettype none

`include "cim_cfg.svh"

module cim_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int W              = `CIM_WORD_W;
    localparam int IDW            = `CIM_ID_W;
    localparam int NPATCH         = `CIM_NUM_PATCHES;
    localparam int TILE_ID        = 2;
    localparam int WAIT_LIMIT     = 60;
    localparam int FOREIGN_WINDOW = 20;

    logic               clk;
    logic               rst_n;
    cim_pkg::bus_word_t bus_in;
    cim_pkg::bus_word_t bus_out;
    logic               bus_drive;
    logic               is_ready;

    logic [W-1:0]       param_model  [`CIM_PARAM_DEPTH];
    logic [W-1:0]       intres_model [`CIM_INTRES_DEPTH];
    logic [31:0]        lfsr;
    cim_pkg::bus_word_t exp_out;
    bit                 drive_expected; // A beat from this tile is due
    bit                 infer_started;
    int                 errors;
    int                 timeouts;
    int                 beats;

    tb_clock clock_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    cim #(.ID(TILE_ID)) dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_in    (bus_in),
        .bus_out   (bus_out),
        .bus_drive (bus_drive),
        .is_ready  (is_ready)
    );

    // Ready and silent until the last patch goes out
    assert property (@(posedge clk) disable iff (!rst_n)
        !infer_started |-> (is_ready && !bus_drive))
    else begin
        $display("CHECK FAILED at %0t: tile not idle before inference (is_ready=%b bus_drive=%b)",
                 $time, $sampled(is_ready), $sampled(bus_drive));
        errors++;
    end

    assert property (@(posedge clk) disable iff (!rst_n) bus_drive |-> drive_expected)
    else begin
        $display("CHECK FAILED at %0t: bus_drive pulse without a start for tile %0d",
                 $time, TILE_ID);
        errors++;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (bus_drive && drive_expected) |-> (bus_out == exp_out))
    else begin
        $display("CHECK FAILED at %0t: broadcast beat %h, expected %h",
                 $time, $sampled(bus_out), exp_out);
        errors++;
    end

    assert property (@(posedge clk) disable iff (!rst_n) bus_drive |-> !is_ready)
    else begin
        $display("CHECK FAILED at %0t: is_ready high while driving the bus", $time);
        errors++;
    end

    // Galois form with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_word(output logic [W-1:0] w);
        for (int b = 0; b < W; b++) begin
            w[b] = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // One bus beat followed by NOP
    task automatic send_beat(input cim_pkg::bus_op_t op, input int tgt,
                             input logic [W-1:0] d0, input logic [W-1:0] d1,
                             input logic [W-1:0] d2);
        bus_in.op               = op;
        bus_in.target_or_sender = IDW'(tgt);
        bus_in.data[0]          = d0;
        bus_in.data[1]          = d1;
        bus_in.data[2]          = d2;
        @(posedge clk);
        #5;
        bus_in = '0;
    endtask

    // Beats for tiles 1 and 3 are mixed in and must not touch this tile
    task automatic stream_params(input int base, input int n_words);
        logic [W-1:0] d [3];
        logic [W-1:0] junk;
        send_beat(cim_pkg::PARAM_STREAM_START_OP, TILE_ID, W'(base), '0, '0);
        for (int k = 0; k < n_words; k++) begin
            if (k % 2 == 0) begin
                rand_word(junk);
                send_beat(cim_pkg::PARAM_STREAM_OP, 1 + (k % 4), junk, ~junk, junk);
            end
            for (int s = 0; s < 3; s++) begin
                rand_word(d[s]);
            end
            send_beat(cim_pkg::PARAM_STREAM_OP, TILE_ID, d[0], d[1], d[2]);
            param_model[base + k] = d[k % 3]; // Slot index cycles 0, 1, 2
        end
    endtask

    task automatic load_patches();
        logic [W-1:0] p;
        send_beat(cim_pkg::PATCH_LOAD_BROADCAST_START_OP, 0, '0, '0, '0);
        for (int i = 0; i < NPATCH; i++) begin
            rand_word(p);
            intres_model[`CIM_PATCH_MEM + i] = p;
            if (i == NPATCH - 1) begin
                infer_started = 1'b1;
            end
            send_beat(cim_pkg::PATCH_LOAD_BROADCAST_OP, 0, p, '0, '0);
        end
    endtask

    // Class token copy followed by the positional add over the token and every patch
    task automatic run_model();
        int a;
        intres_model[`CIM_CLASS_TOKEN_MEM] = param_model[`CIM_CLASS_TOKEN_OFF];
        for (int i = 0; i <= NPATCH; i++) begin
            a = `CIM_CLASS_TOKEN_MEM + i;
            intres_model[a] = intres_model[a] + param_model[`CIM_POS_EMB_OFF + i];
        end
    endtask

    task automatic wait_ready(input logic level, input string what);
        int n;
        n = 0;
        while (is_ready !== level && n < WAIT_LIMIT) begin
            @(posedge clk);
            #5;
            n++;
        end
        if (is_ready !== level) begin
            $display("ERROR: is_ready did not %s within %0d cycles", what, WAIT_LIMIT);
            timeouts++;
        end
    endtask

    task automatic wait_drive(input int limit, output bit seen);
        int n;
        n = 0;
        while (bus_drive !== 1'b1 && n < limit) begin
            @(posedge clk);
            #5;
            n++;
        end
        seen = (bus_drive === 1'b1);
        if (seen) begin
            beats++;
            @(posedge clk); // Let the assertions sample the beat
            #5;
        end
    endtask

    task automatic check_transmit(input int addr, input int len);
        bit seen;
        exp_out                  = '0;
        exp_out.op               = cim_pkg::DENSE_BROADCAST_DATA_OP;
        exp_out.target_or_sender = IDW'(TILE_ID);
        if (len == 1) begin
            exp_out.data[2] = intres_model[addr];
        end else begin
            for (int j = 0; j < 3; j++) begin
                exp_out.data[j] = intres_model[addr + j];
            end
        end
        wait_ready(1'b1, "rise before a transmit");
        drive_expected = 1'b1;
        send_beat(cim_pkg::DENSE_BROADCAST_START_OP, TILE_ID, W'(addr), W'(len), '0);
        wait_drive(WAIT_LIMIT, seen);
        drive_expected = 1'b0;
        if (!seen) begin
            $display("ERROR: no broadcast beat within %0d cycles for address %0d",
                     WAIT_LIMIT, addr);
            timeouts++;
        end
    endtask

    initial begin
        int  n;
        bit  seen;
        bus_in         = '0;
        lfsr           = 32'h0f80b1e6;
        exp_out        = '0;
        drive_expected = 1'b0;
        infer_started  = 1'b0;
        errors         = 0;
        timeouts       = 0;
        beats          = 0;
        for (int a = 0; a < `CIM_PARAM_DEPTH; a++) begin
            param_model[a]  = '0;
            intres_model[a] = '0;
        end

        n = 0;
        while (rst_n !== 1'b1 && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("ERROR: reset was never released");
            timeouts++;
        end
        @(posedge clk);
        #5;

        stream_params(`CIM_CLASS_TOKEN_OFF, 1);
        stream_params(`CIM_POS_EMB_OFF, NPATCH + 1);
        load_patches();
        run_model();

        wait_ready(1'b0, "fall after the patch load");
        wait_ready(1'b1, "rise after the inference");

        check_transmit(0, 3);
        check_transmit(4, 1);

        // Start aimed at tile 1
        wait_ready(1'b1, "rise before the foreign start");
        send_beat(cim_pkg::DENSE_BROADCAST_START_OP, 1, '0, 16'd3, '0);
        wait_drive(FOREIGN_WINDOW, seen);
        wait_ready(1'b1, "stay high after the foreign start");

        $display("Errors: %0d, timeouts: %0d, broadcast beats seen: %0d",
                 errors, timeouts, beats);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+verilog
verilog/cim_pkg.sv
verilog/cim_mem.sv
verilog/cim_bus_rx.sv
verilog/cim_compute_ctrl.sv
verilog/cim_bus_tx.sv
verilog/cim.sv
sim/tb_clock.sv
sim/cim_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the tile testbench with Verilator, runs it and checks the log for a pass
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module cim_tb -f verilog.f -o cim_tb_sim

./obj_dir/cim_tb_sim | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
    exit 0
fi
exit 1
